/* include/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Data word width of every CSR
`define CSR_XLEN 32

// Software writable bits per register
`define CSR_MSTATUS_WMASK 32'h0000_1888 // MPP[12:11], MPIE, MIE
`define CSR_MIE_WMASK     32'h0000_0888 // MEIE, MTIE, MSIE
`define CSR_MTVEC_WMASK   32'hFFFF_FFFC // Mode bits held at zero, direct only
`define CSR_MEPC_WMASK    32'hFFFF_FFFC // Word aligned return address

// mstatus bit positions
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7

// Flops per interrupt line before it reaches mip
`define CSR_IRQ_SYNC_STAGES 2

// Software write strobe index into the trap unit
`define CSR_SW_MSTATUS 0
`define CSR_SW_MEPC    1
`define CSR_SW_MCAUSE  2
`define CSR_SW_MTVAL   3
`define CSR_SW_COUNT   4

`endif

/* design/csr_pkg.sv */
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

    // Machine mode CSR numbers handled by the bank
    typedef enum logic [11:0] {
        MSTATUS    = 12'h300,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MVENDORID  = 12'hF11, // ID block, all read zero
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_t;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_t;

    // Synchronous exception causes
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        ILLEGAL_INSTRUCTION   = 4'd2,
        BREAKPOINT            = 4'd3,
        LOAD_ADDR_MISALIGNED  = 4'd4,
        LOAD_ACCESS_FAULT     = 4'd5,
        STORE_ADDR_MISALIGNED = 4'd6,
        STORE_ACCESS_FAULT    = 4'd7,
        ECALL_FROM_UMODE      = 4'd8,
        ECALL_FROM_SMODE      = 4'd9,
        ECALL_FROM_MMODE      = 4'd11
    } exc_code_t;

    // Interrupt causes, value doubles as the mip/mie bit index
    typedef enum logic [3:0] {
        IRQ_NONE  = 4'd0,
        M_SW_INT  = 4'd3,
        M_TIM_INT = 4'd7,
        M_EXT_INT = 4'd11
    } irq_code_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    typedef struct packed {
        logic [19:0] rsvd_31_12;
        logic        meie;       // Bit 11
        logic [2:0]  rsvd_10_8;
        logic        mtie;       // Bit 7
        logic [2:0]  rsvd_6_4;
        logic        msie;       // Bit 3
        logic [2:0]  rsvd_2_0;
    } mie_t;

    // Read-modify-write rule shared by every writable CSR
    function automatic logic [`CSR_XLEN-1:0] csr_rmw(
        input csr_op_t               op,
        input logic [`CSR_XLEN-1:0] cur,
        input logic [`CSR_XLEN-1:0] data,
        input logic [`CSR_XLEN-1:0] mask
    );
        logic [`CSR_XLEN-1:0] nxt;
        case (op)
            CSR_WRITE: nxt = data;
            CSR_SET:   nxt = cur | data;
            CSR_CLEAR: nxt = cur & ~data;
            default:   nxt = cur;       // No op keeps the value
        endcase
        return nxt & mask;
    endfunction

endpackage

`default_nettype wire

/* design/csr_field.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_field import csr_pkg::*; #(
    parameter type                  T     = logic [`CSR_XLEN-1:0],
    parameter logic [`CSR_XLEN-1:0] WMASK = '1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_stb,  // Decoded software write
    input  csr_op_t              op,
    input  logic [`CSR_XLEN-1:0] wr_data, // Raw operand from the pipeline
    output T                     value
);

    logic [`CSR_XLEN-1:0] q;   // Flat storage
    logic [`CSR_XLEN-1:0] nxt;

    // Masked RMW against the current contents
    always_comb begin
        nxt = csr_rmw(op, q, wr_data, WMASK);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            q <= '0;
        end else if (wr_stb) begin
            q <= nxt;
        end
    end

    // Payload view, word or struct
    assign value = T'(q);

endmodule

`default_nettype wire

/* design/csr_irq_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_irq_sync import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 irq_ext, // Async sources
    input  logic                 irq_sw,
    input  logic                 irq_tim,
    output logic [`CSR_XLEN-1:0] mip
);

    localparam int S = `CSR_IRQ_SYNC_STAGES;

    logic [S-1:0] ext_q; // LSB is the first flop
    logic [S-1:0] sw_q;
    logic [S-1:0] tim_q;

    always_ff @(posedge clk) begin
        if (!reset) begin
            ext_q <= '0;
            sw_q  <= '0;
            tim_q <= '0;
        end else begin
            ext_q <= {ext_q[S-2:0], irq_ext};
            sw_q  <= {sw_q[S-2:0], irq_sw};
            tim_q <= {tim_q[S-2:0], irq_tim};
        end
    end

    // Last stage lands on the standard pending bits
    always_comb begin
        mip            = '0;
        mip[M_EXT_INT] = ext_q[S-1]; // MEIP
        mip[M_SW_INT]  = sw_q[S-1];  // MSIP
        mip[M_TIM_INT] = tim_q[S-1]; // MTIP
    end

endmodule

`default_nettype wire

/* design/csr_irq_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_irq_arbiter import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mstatus_mie, // Global enable
    input  mie_t                 mie,
    input  logic [`CSR_XLEN-1:0] mip,
    input  logic                 irq_ack,
    output logic                 irq_pending,
    output irq_code_t            irq_code
);

    logic [`CSR_XLEN-1:0] pend;   // Enabled and pending
    logic                 fire;
    irq_code_t            winner;

    assign pend = mie & mip;
    assign fire = mstatus_mie && (|pend) && !irq_ack; // Ack masks the same cycle

    // Fixed priority, external then software then timer
    always_comb begin
        if (pend[M_EXT_INT]) begin
            winner = M_EXT_INT;
        end else if (pend[M_SW_INT]) begin
            winner = M_SW_INT;
        end else if (pend[M_TIM_INT]) begin
            winner = M_TIM_INT;
        end else begin
            winner = IRQ_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            irq_pending <= 1'b0;
            irq_code    <= IRQ_NONE;
        end else begin
            irq_pending <= fire;
            if (fire) begin
                irq_code <= winner; // Held while nothing fires
            end
        end
    end

endmodule

`default_nettype wire

/* design/csr_trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_trap_unit import csr_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     raise_exception,
    input  exc_code_t                exc_code,
    input  logic                     machine_return,
    input  logic                     irq_ack,
    input  irq_code_t                irq_code,
    input  priv_t                    privilege,   // Mode the trap was taken from
    input  logic [`CSR_XLEN-1:0]     pc,
    input  logic [`CSR_XLEN-1:0]     instruction,
    input  logic [`CSR_SW_COUNT-1:0] sw_wr_stb,   // One per owned register
    input  logic [`CSR_XLEN-1:0]     sw_wr_data,  // Already masked by the bank
    output logic [`CSR_XLEN-1:0]     mstatus,
    output logic [`CSR_XLEN-1:0]     mepc,
    output logic [`CSR_XLEN-1:0]     mcause,
    output logic [`CSR_XLEN-1:0]     mtval
);

    localparam int MIE  = `CSR_MSTATUS_MIE_BIT;
    localparam int MPIE = `CSR_MSTATUS_MPIE_BIT;

    logic [`CSR_XLEN-1:0] exc_epc;
    logic [`CSR_XLEN-1:0] exc_tval;

    // ECALL from M returns to itself, others skip the faulting word
    assign exc_epc  = (exc_code == ECALL_FROM_MMODE) ? pc : pc + `CSR_XLEN'(4);
    assign exc_tval = (exc_code == ILLEGAL_INSTRUCTION) ? instruction : pc;

    always_ff @(posedge clk) begin
        if (!reset) begin
            mstatus <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mtval   <= '0;
        end else if (machine_return) begin
            mstatus[MIE] <= mstatus[MPIE]; // Restore global enable
        end else if (raise_exception) begin
            mcause         <= {1'b0, {(`CSR_XLEN-5){1'b0}}, exc_code};
            mstatus[12:11] <= privilege;    // MPP
            mstatus[MPIE]  <= mstatus[MIE];
            mstatus[MIE]   <= 1'b0;
            mepc           <= exc_epc;
            mtval          <= exc_tval;
        end else if (irq_ack) begin
            // Interrupt flag in the top bit
            mcause         <= {1'b1, {(`CSR_XLEN-5){1'b0}}, irq_code};
            mstatus[12:11] <= privilege;
            mstatus[MPIE]  <= mstatus[MIE];
            mstatus[MIE]   <= 1'b0;
            mepc           <= pc;           // Interrupted instruction reruns
        end else begin
            if (sw_wr_stb[`CSR_SW_MSTATUS]) begin
                mstatus <= sw_wr_data;
            end
            if (sw_wr_stb[`CSR_SW_MEPC]) begin
                mepc <= sw_wr_data;
            end
            if (sw_wr_stb[`CSR_SW_MCAUSE]) begin
                mcause <= sw_wr_data;
            end
            if (sw_wr_stb[`CSR_SW_MTVAL]) begin
                mtval <= sw_wr_data;
            end
        end
    end

endmodule

`default_nettype wire

/* design/csr_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_bank import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [11:0]          addr,
    input  csr_op_t              op,
    input  logic [`CSR_XLEN-1:0] wr_data,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  logic                 killed,   // Squashed in the pipeline
    input  logic                 raise_exception,
    input  exc_code_t            exc_code,
    input  logic                 machine_return,
    input  logic                 irq_ack,
    input  priv_t                privilege,
    input  logic [`CSR_XLEN-1:0] pc,
    input  logic [`CSR_XLEN-1:0] instruction,
    input  logic [`CSR_XLEN-1:0] mip,      // From the synchroniser
    output logic [`CSR_XLEN-1:0] rd_data,
    output logic                 irq_pending,
    output irq_code_t            irq_code,
    output logic [`CSR_XLEN-1:0] trap_vector,
    output logic [`CSR_XLEN-1:0] return_pc
);

    csr_addr_t                csr;
    logic                     sw_ok;
    logic                     wr_mie, wr_mtvec, wr_mscratch;
    logic [`CSR_SW_COUNT-1:0] tu_stb;     // Strobes into the trap unit
    logic [`CSR_XLEN-1:0]     tu_cur;     // Current value for RMW
    logic [`CSR_XLEN-1:0]     tu_mask;
    logic [`CSR_XLEN-1:0]     tu_wr_data;
    logic [`CSR_XLEN-1:0]     mstatus, mepc, mcause, mtval, mtvec, mscratch;
    mie_t                     mie;

    assign csr   = csr_addr_t'(addr);
    // Any trap in the same cycle wins over software
    assign sw_ok = wr_en && !killed && !machine_return && !raise_exception && !irq_ack;

    // One hot write decode, ID block and mip ignored
    always_comb begin
        wr_mie      = 1'b0;
        wr_mtvec    = 1'b0;
        wr_mscratch = 1'b0;
        tu_stb      = '0;
        if (sw_ok) begin
            case (csr)
                MSTATUS:  tu_stb[`CSR_SW_MSTATUS] = 1'b1;
                MIE:      wr_mie                  = 1'b1;
                MTVEC:    wr_mtvec                = 1'b1;
                MSCRATCH: wr_mscratch             = 1'b1;
                MEPC:     tu_stb[`CSR_SW_MEPC]    = 1'b1;
                MCAUSE:   tu_stb[`CSR_SW_MCAUSE]  = 1'b1;
                MTVAL:    tu_stb[`CSR_SW_MTVAL]   = 1'b1;
                default:  ;
            endcase
        end
    end

    // Operand and mask for the trap unit registers
    always_comb begin
        case (csr)
            MSTATUS: begin tu_cur = mstatus; tu_mask = `CSR_MSTATUS_WMASK; end
            MEPC:    begin tu_cur = mepc;    tu_mask = `CSR_MEPC_WMASK;    end
            MCAUSE:  begin tu_cur = mcause;  tu_mask = '1;                 end
            MTVAL:   begin tu_cur = mtval;   tu_mask = '1;                 end
            default: begin tu_cur = '0;      tu_mask = '0;                 end
        endcase
        tu_wr_data = csr_rmw(op, tu_cur, wr_data, tu_mask);
    end

    csr_field #(.T(logic [`CSR_XLEN-1:0]), .WMASK('1)) u_mscratch (
        .clk(clk), .reset(reset), .wr_stb(wr_mscratch),
        .op(op), .wr_data(wr_data), .value(mscratch)
    );

    csr_field #(.T(logic [`CSR_XLEN-1:0]), .WMASK(`CSR_MTVEC_WMASK)) u_mtvec (
        .clk(clk), .reset(reset), .wr_stb(wr_mtvec),
        .op(op), .wr_data(wr_data), .value(mtvec)
    );

    csr_field #(.T(mie_t), .WMASK(`CSR_MIE_WMASK)) u_mie (
        .clk(clk), .reset(reset), .wr_stb(wr_mie),
        .op(op), .wr_data(wr_data), .value(mie)
    );

    csr_trap_unit u_trap_unit (
        .clk(clk), .reset(reset),
        .raise_exception(raise_exception), .exc_code(exc_code),
        .machine_return(machine_return), .irq_ack(irq_ack),
        .irq_code(irq_code), .privilege(privilege),
        .pc(pc), .instruction(instruction),
        .sw_wr_stb(tu_stb), .sw_wr_data(tu_wr_data),
        .mstatus(mstatus), .mepc(mepc), .mcause(mcause), .mtval(mtval)
    );

    csr_irq_arbiter u_irq_arbiter (
        .clk(clk), .reset(reset),
        .mstatus_mie(mstatus[`CSR_MSTATUS_MIE_BIT]),
        .mie(mie), .mip(mip), .irq_ack(irq_ack),
        .irq_pending(irq_pending), .irq_code(irq_code) // Code also feeds mcause
    );

    // Combinational read port
    always_comb begin
        rd_data = '0;
        if (rd_en && !killed) begin
            case (csr)
                MSTATUS:  rd_data = mstatus;
                MIE:      rd_data = mie;
                MTVEC:    rd_data = mtvec;
                MSCRATCH: rd_data = mscratch;
                MEPC:     rd_data = mepc;
                MCAUSE:   rd_data = mcause;
                MTVAL:    rd_data = mtval;
                MIP:      rd_data = mip;
                default:  rd_data = '0; // ID registers and unknown
            endcase
        end
    end

    // Fetch side copies, one cycle behind
    always_ff @(posedge clk) begin
        if (!reset) begin
            trap_vector <= '0;
            return_pc   <= '0;
        end else begin
            trap_vector <= mtvec;
            return_pc   <= mepc;
        end
    end

endmodule

`default_nettype wire

/* design/csr_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_top import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [11:0]          addr,
    input  csr_op_t              op,
    input  logic [`CSR_XLEN-1:0] wr_data,
    input  logic                 rd_en,
    input  logic                 wr_en,
    input  logic                 killed,
    input  logic                 raise_exception,
    input  exc_code_t            exc_code,
    input  logic                 machine_return,
    input  logic                 irq_ack,
    input  priv_t                privilege,
    input  logic [`CSR_XLEN-1:0] pc,
    input  logic [`CSR_XLEN-1:0] instruction,
    input  logic                 irq_ext,  // Asynchronous lines
    input  logic                 irq_sw,
    input  logic                 irq_tim,
    output logic [`CSR_XLEN-1:0] rd_data,
    output logic                 irq_pending,
    output irq_code_t            irq_code,
    output logic [`CSR_XLEN-1:0] trap_vector,
    output logic [`CSR_XLEN-1:0] return_pc
);

    logic [`CSR_XLEN-1:0] mip;

    csr_irq_sync u_irq_sync (
        .clk(clk), .reset(reset),
        .irq_ext(irq_ext), .irq_sw(irq_sw), .irq_tim(irq_tim),
        .mip(mip)
    );

    csr_bank u_bank (
        .clk(clk), .reset(reset),
        .addr(addr), .op(op), .wr_data(wr_data),
        .rd_en(rd_en), .wr_en(wr_en), .killed(killed),
        .raise_exception(raise_exception), .exc_code(exc_code),
        .machine_return(machine_return), .irq_ack(irq_ack),
        .privilege(privilege), .pc(pc), .instruction(instruction),
        .mip(mip), .rd_data(rd_data),
        .irq_pending(irq_pending), .irq_code(irq_code),
        .trap_vector(trap_vector), .return_pc(return_pc)
    );

endmodule

`default_nettype wire

/* tb/csr_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_chk import csr_pkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic [11:0]          addr,
    input logic [1:0]           op,
    input logic [`CSR_XLEN-1:0] wr_data,
    input logic                 rd_en,
    input logic                 wr_en,
    input logic                 killed,
    input logic                 raise_exception,
    input logic [3:0]           exc_code,
    input logic                 machine_return,
    input logic                 irq_ack,
    input logic [1:0]           privilege,
    input logic [`CSR_XLEN-1:0] pc,
    input logic [`CSR_XLEN-1:0] instruction,
    input logic                 irq_ext,
    input logic                 irq_sw,
    input logic                 irq_tim,
    input logic [`CSR_XLEN-1:0] rd_data,
    input logic                 irq_pending,
    input logic [3:0]           irq_code,
    input logic [`CSR_XLEN-1:0] trap_vector,
    input logic [`CSR_XLEN-1:0] return_pc
);

    localparam int S = `CSR_IRQ_SYNC_STAGES;

    int err_count = 0; // Failed assertions

    // Shadow copies of the architectural state
    logic [`CSR_XLEN-1:0] sh_mstatus;
    logic [`CSR_XLEN-1:0] sh_mie;
    logic [`CSR_XLEN-1:0] sh_mtvec;
    logic [`CSR_XLEN-1:0] sh_mscratch;
    logic [`CSR_XLEN-1:0] sh_mepc;
    logic [`CSR_XLEN-1:0] sh_mcause;
    logic [`CSR_XLEN-1:0] sh_mtval;
    logic [`CSR_XLEN-1:0] sh_mip;
    logic [`CSR_XLEN-1:0] sh_tv;      // mtvec one cycle late
    logic [`CSR_XLEN-1:0] sh_rp;      // mepc one cycle late
    logic [S-1:0]         ext_p;
    logic [S-1:0]         sw_p;
    logic [S-1:0]         tim_p;
    logic                 sh_pending;
    logic [3:0]           sh_code;
    logic [`CSR_XLEN-1:0] pend;
    logic                 fire;
    logic                 sw_wr;
    logic [`CSR_XLEN-1:0] cur;        // Shadow value at addr
    logic [`CSR_XLEN-1:0] upd;        // Unmasked write result
    logic [`CSR_XLEN-1:0] exp_rd;

    always_comb begin
        sh_mip     = '0;
        sh_mip[11] = ext_p[S-1]; // MEIP
        sh_mip[3]  = sw_p[S-1];  // MSIP
        sh_mip[7]  = tim_p[S-1]; // MTIP
        pend       = sh_mie & sh_mip;
        fire       = sh_mstatus[3] && (|pend) && !irq_ack;
        sw_wr      = wr_en && !killed && !machine_return && !raise_exception && !irq_ack;
    end

    // Expected read value and write result
    always_comb begin
        case (addr)
            MSTATUS:  cur = sh_mstatus;
            MIE:      cur = sh_mie;
            MTVEC:    cur = sh_mtvec;
            MSCRATCH: cur = sh_mscratch;
            MEPC:     cur = sh_mepc;
            MCAUSE:   cur = sh_mcause;
            MTVAL:    cur = sh_mtval;
            MIP:      cur = sh_mip;
            default:  cur = '0;  // ID block and holes
        endcase
        exp_rd = (rd_en && !killed) ? cur : '0;
        case (op)
            CSR_WRITE: upd = wr_data;
            CSR_SET:   upd = cur | wr_data;
            CSR_CLEAR: upd = cur & ~wr_data;
            default:   upd = cur;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            sh_mstatus  <= '0;
            sh_mie      <= '0;
            sh_mtvec    <= '0;
            sh_mscratch <= '0;
            sh_mepc     <= '0;
            sh_mcause   <= '0;
            sh_mtval    <= '0;
            sh_tv       <= '0;
            sh_rp       <= '0;
            ext_p       <= '0;
            sw_p        <= '0;
            tim_p       <= '0;
            sh_pending  <= 1'b0;
            sh_code     <= 4'd0;
        end else begin
            ext_p      <= {ext_p[S-2:0], irq_ext};
            sw_p       <= {sw_p[S-2:0], irq_sw};
            tim_p      <= {tim_p[S-2:0], irq_tim};
            sh_tv      <= sh_mtvec;
            sh_rp      <= sh_mepc;
            sh_pending <= fire;
            if (fire) begin
                sh_code <= pend[11] ? 4'd11 : (pend[3] ? 4'd3 : 4'd7); // Ext, sw, tim
            end
            if (machine_return) begin
                sh_mstatus[3] <= sh_mstatus[7];
            end else if (raise_exception || irq_ack) begin
                sh_mstatus[12:11] <= privilege;
                sh_mstatus[7]     <= sh_mstatus[3];
                sh_mstatus[3]     <= 1'b0;
                if (raise_exception) begin
                    sh_mcause <= {28'd0, exc_code};
                    sh_mepc   <= (exc_code == ECALL_FROM_MMODE) ? pc : pc + 32'd4;
                    sh_mtval  <= (exc_code == ILLEGAL_INSTRUCTION) ? instruction : pc;
                end else begin
                    sh_mcause <= {1'b1, 27'd0, sh_code}; // Interrupt flag set
                    sh_mepc   <= pc;
                end
            end else if (sw_wr) begin
                case (addr)
                    MSTATUS:  sh_mstatus  <= upd & `CSR_MSTATUS_WMASK;
                    MIE:      sh_mie      <= upd & `CSR_MIE_WMASK;
                    MTVEC:    sh_mtvec    <= upd & `CSR_MTVEC_WMASK;
                    MSCRATCH: sh_mscratch <= upd;
                    MEPC:     sh_mepc     <= upd & `CSR_MEPC_WMASK;
                    MCAUSE:   sh_mcause   <= upd;
                    MTVAL:    sh_mtval    <= upd;
                    default:  ;
                endcase
            end
        end
    end

    a_rd_data: assert property (@(posedge clk) disable iff (!reset) rd_data == exp_rd)
        else begin
            err_count++;
            $error("Mismatch at %0t: rd_data got %h expected %h",
                   $time, $sampled(rd_data), $sampled(exp_rd));
        end

    a_pending: assert property (@(posedge clk) disable iff (!reset) irq_pending == sh_pending)
        else begin
            err_count++;
            $error("Mismatch at %0t: irq_pending got %b expected %b",
                   $time, $sampled(irq_pending), $sampled(sh_pending));
        end

    a_code: assert property (@(posedge clk) disable iff (!reset) irq_code == sh_code)
        else begin
            err_count++;
            $error("Mismatch at %0t: irq_code got %0d expected %0d",
                   $time, $sampled(irq_code), $sampled(sh_code));
        end

    a_trap_vector: assert property (@(posedge clk) disable iff (!reset) trap_vector == sh_tv)
        else begin
            err_count++;
            $error("Mismatch at %0t: trap_vector got %h expected %h",
                   $time, $sampled(trap_vector), $sampled(sh_tv));
        end

    a_return_pc: assert property (@(posedge clk) disable iff (!reset) return_pc == sh_rp)
        else begin
            err_count++;
            $error("Mismatch at %0t: return_pc got %h expected %h",
                   $time, $sampled(return_pc), $sampled(sh_rp));
        end

    // Pending never beats the synchroniser
    a_sync_delay: assert property (@(posedge clk) disable iff (!reset)
        $rose(irq_pending) |-> $past(irq_ext || irq_sw || irq_tim, S + 1))
        else begin
            err_count++;
            $error("irq_pending rose at %0t before an interrupt line crossed the synchroniser",
                   $time);
        end

endmodule

`default_nettype wire

/* tb/csr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_tb import csr_pkg::*; ();

    localparam int RAND_OPS     = 300;                       // Write then read pairs
    localparam int DIRECTED_OPS = 400;                       // Bound on directed cycles
    localparam int MARGIN_NS    = 2000;
    localparam int IRQ_WAIT     = `CSR_IRQ_SYNC_STAGES + 4;  // Cycles until pending

    localparam logic [11:0] RW_REGS [7] = '{MSCRATCH, MTVEC, MIE, MSTATUS, MEPC, MCAUSE, MTVAL};
    localparam logic [11:0] RO_REGS [8] = '{MVENDORID, MARCHID, MIMPID, MHARTID,
                                            MCONFIGPTR, MIP, 12'h7C0, 12'hFFF};
    localparam exc_code_t EXC_CODES [8] = '{ILLEGAL_INSTRUCTION, BREAKPOINT, ECALL_FROM_MMODE,
                                           ECALL_FROM_UMODE, LOAD_ACCESS_FAULT,
                                           STORE_ADDR_MISALIGNED, ILLEGAL_INSTRUCTION,
                                           ECALL_FROM_MMODE};
    localparam priv_t PRIVS [3] = '{PRIV_U, PRIV_S, PRIV_M};
    localparam logic [2:0] IRQ_SETS [6] = '{3'b100, 3'b010, 3'b001, 3'b011, 3'b101, 3'b111};

    logic                 clk;
    logic                 reset;
    logic [11:0]          addr;
    csr_op_t              op;
    logic [`CSR_XLEN-1:0] wr_data;
    logic                 rd_en;
    logic                 wr_en;
    logic                 killed;
    logic                 raise_exception;
    exc_code_t            exc_code;
    logic                 machine_return;
    logic                 irq_ack;
    priv_t                privilege;
    logic [`CSR_XLEN-1:0] pc;
    logic [`CSR_XLEN-1:0] instruction;
    logic                 irq_ext;
    logic                 irq_sw;
    logic                 irq_tim;
    logic [`CSR_XLEN-1:0] rd_data;
    logic                 irq_pending;
    irq_code_t            irq_code;
    logic [`CSR_XLEN-1:0] trap_vector;
    logic [`CSR_XLEN-1:0] return_pc;

    logic [31:0] rng = 32'h68ec_30a3;
    int          tb_errors = 0; // Timeouts seen by the stimulus

    csr_top UUT (.*);

    bind csr_top csr_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    // Strobes and op back to idle
    task automatic clear_strobes();
        rd_en           = 1'b0;
        wr_en           = 1'b0;
        killed          = 1'b0;
        op              = CSR_NONE;
        raise_exception = 1'b0;
        machine_return  = 1'b0;
        irq_ack         = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_csr(input logic [11:0] a, input csr_op_t o,
                             input logic [31:0] d, input logic k);
        clear_strobes();
        addr    = a;
        op      = o;
        wr_data = d;
        wr_en   = 1'b1;
        rd_en   = 1'b1; // Old value is read in the same cycle
        killed  = k;
        next_cycle();
    endtask

    task automatic read_csr(input logic [11:0] a, input logic k);
        clear_strobes();
        addr   = a;
        rd_en  = 1'b1;
        killed = k;
        next_cycle();
    endtask

    // Watchdog sized from the test length
    initial begin
        #((RAND_OPS * 2 + DIRECTED_OPS) * 20 + MARGIN_NS);
        $display("Watchdog expired at %0t, the run did not complete", $time);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        int          waited;
        int          total;
        reset       = 1'b0;
        addr        = '0;
        wr_data     = '0;
        exc_code    = ILLEGAL_INSTRUCTION;
        privilege   = PRIV_M;
        pc          = '0;
        instruction = '0;
        irq_ext     = 1'b0;
        irq_sw      = 1'b0;
        irq_tim     = 1'b0;
        clear_strobes();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b1;

        // Random RMW traffic with some writes killed
        for (int i = 0; i < RAND_OPS; i++) begin
            roll(r);
            roll(d);
            write_csr(RW_REGS[r[2:0] % 7], csr_op_t'(2'd1 + r[9:8] % 3), d, r[15:13] == 3'd0);
            read_csr(RW_REGS[r[2:0] % 7], 1'b0);
        end

        // ID block, mip and holes ignore writes
        for (int i = 0; i < 8; i++) begin
            roll(d);
            write_csr(RO_REGS[i], CSR_WRITE, d, 1'b0);
            read_csr(RO_REGS[i], 1'b0);
        end
        for (int i = 0; i < 7; i++) begin
            read_csr(RW_REGS[i], 1'b0);
            read_csr(RW_REGS[i], 1'b1); // Killed read gives zero
        end

        // Exceptions racing a software write
        for (int i = 0; i < 24; i++) begin
            roll(r);
            roll(d);
            write_csr(MSTATUS, CSR_WRITE, r, 1'b0);
            clear_strobes();
            raise_exception = 1'b1;
            exc_code        = EXC_CODES[r[2:0]];
            privilege       = PRIVS[r[5:4] % 3];
            pc              = d & 32'hFFFF_FFFC;
            roll(instruction);
            addr            = r[8] ? MTVAL : MEPC;
            op              = CSR_WRITE;
            wr_data         = ~d;
            wr_en           = 1'b1;
            next_cycle();
            read_csr(MEPC, 1'b0);
            read_csr(MTVAL, 1'b0);
            read_csr(MCAUSE, 1'b0);
            read_csr(MSTATUS, 1'b0);
        end

        // mret with MPIE set, then with MPIE clear
        for (int i = 0; i < 2; i++) begin
            write_csr(MSTATUS, CSR_WRITE, (i == 0) ? 32'h0000_0080 : 32'h0000_0008, 1'b0);
            roll(d);
            clear_strobes();
            machine_return = 1'b1;
            addr           = MSCRATCH; // Write lost to the return
            op             = CSR_WRITE;
            wr_data        = d;
            wr_en          = 1'b1;
            next_cycle();
            read_csr(MSTATUS, 1'b0);
            read_csr(MEPC, 1'b0);
            read_csr(MSCRATCH, 1'b0);
        end

        // Interrupt lines alone and together
        write_csr(MIE, CSR_WRITE, 32'hFFFF_FFFF, 1'b0);
        for (int k = 0; k < 6; k++) begin
            write_csr(MSTATUS, CSR_SET, 32'h0000_0008, 1'b0);
            clear_strobes();
            {irq_ext, irq_sw, irq_tim} = IRQ_SETS[k];
            addr  = MIP;  // mip read back while the lines cross
            rd_en = 1'b1;
            waited = 0;
            while (!irq_pending && waited < IRQ_WAIT) begin
                next_cycle();
                waited++;
            end
            if (!irq_pending) begin
                tb_errors++;
                $display("Timeout at %0t: irq_pending never rose for lines %b",
                         $time, IRQ_SETS[k]);
            end
            roll(d);
            irq_ack = 1'b1;
            pc      = d & 32'hFFFF_FFFC;
            irq_ext = 1'b0;
            irq_sw  = 1'b0;
            irq_tim = 1'b0;
            next_cycle();
            read_csr(MCAUSE, 1'b0);
            read_csr(MEPC, 1'b0);
            read_csr(MSTATUS, 1'b0);
            clear_strobes();
            repeat (`CSR_IRQ_SYNC_STAGES + 1) next_cycle(); // mip drains
        end

        clear_strobes();
        repeat (3) next_cycle();
        total = UUT.u_chk.err_count + tb_errors;
        $display("Errors: %0d assertion failures, %0d testbench failures",
                 UUT.u_chk.err_count, tb_errors);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
design/csr_pkg.sv
design/csr_field.sv
design/csr_irq_sync.sv
design/csr_irq_arbiter.sv
design/csr_trap_unit.sv
design/csr_bank.sv
design/csr_top.sv
tb/csr_chk.sv
tb/csr_tb.sv
